//--- pianoTiles_defs.svh
`ifndef PIANOTILES_DEFS_SVH
`define PIANOTILES_DEFS_SVH

`define NUM_COLUMNS 4
`define LANE_ROWS 120
`define BLOCK_ROWS 20 // Rows per spawned block, also the longest run one hit clears
`define SPAWN_PERIOD 22

`define TILE_WIDTH 10
`define COLUMN_X0 10
`define COLUMN_PITCH 30

`define FRAME_TICKS 12000 // Clock cycles per frame

`define LFSR_SEED0 31'h1A2B3C4D
`define LFSR_SEED1 31'h2C49E35B
`define LFSR_SEED2 31'h05D1F7A3
`define LFSR_SEED3 31'h3E8B6C17

`endif

//--- gamePkg.sv
`default_nettype none

`include "pianoTiles_defs.svh"

package gamePkg;

	// Bit r of a lane is row r, row 0 at the top
	typedef logic [`LANE_ROWS-1:0] laneT;

	typedef laneT [`NUM_COLUMNS-1:0] lanesT;

	typedef logic [`NUM_COLUMNS-1:0] columnMaskT;

	typedef logic [6:0] rowT;

	typedef logic [1:0] columnT;

	typedef logic [15:0] scoreT;

endpackage

`default_nettype wire

//--- videoPkg.sv
`default_nettype none

package videoPkg;

	typedef logic [7:0] xT;
	typedef logic [6:0] yT;
	typedef logic [2:0] colourT;

	localparam colourT colourDraw = 3'd7;
	localparam colourT colourErase = 3'd0;

	typedef logic [6:0] segmentsT; // Active low, bit 6 is segment g
	typedef segmentsT [3:0] digitsT;

endpackage

`default_nettype wire

//--- renderIf.sv
`timescale 1ns/1ps
`default_nettype none

interface renderIf;

	logic start; // One-cycle pulse, begins a pass
	logic erase; // Held for the whole pass
	logic done;
	gamePkg::rowT rowAddr;
	gamePkg::columnMaskT rowBits; // Four lane bits at rowAddr

	modport controller (output start, output erase, input done);

	modport renderer (input start, input erase, input rowBits, output done, output rowAddr);

	modport lanes (input rowAddr, output rowBits);

endinterface

`default_nettype wire

//--- inputSide.sv
`timescale 1ns/1ps
`default_nettype none

`include "pianoTiles_defs.svh"

module inputSide (
	input logic Clock,
	input logic resetn,
	input logic [3:0] keysN,
	output gamePkg::columnMaskT pressMask,
	output logic frameTick,
	output gamePkg::columnMaskT randomBits
);

	localparam int tickBits = $clog2(`FRAME_TICKS);
	localparam logic [`NUM_COLUMNS-1:0][30:0] lfsrSeeds =
		{`LFSR_SEED3, `LFSR_SEED2, `LFSR_SEED1, `LFSR_SEED0};

	gamePkg::columnMaskT keyLevel;
	gamePkg::columnMaskT keySync1;
	gamePkg::columnMaskT keySync2;
	gamePkg::columnMaskT keyLast;
	logic [tickBits-1:0] tickCount;
	logic [`NUM_COLUMNS-1:0][30:0] lfsr;

	always_comb begin
		for (int c = 0; c < `NUM_COLUMNS; c++) begin
			keyLevel[c] = keysN[`NUM_COLUMNS-1-c]; // keysN[3] is column 0
			randomBits[c] = lfsr[c][0];
		end
	end

	always_ff @(posedge Clock) begin
		if (!resetn) begin
			keySync1 <= '1; // Keys idle high
			keySync2 <= '1;
			keyLast <= '1;
			pressMask <= '0;
		end else begin
			keySync1 <= keyLevel;
			keySync2 <= keySync1;
			keyLast <= keySync2;
			pressMask <= keyLast & ~keySync2; // Falling edge
		end
	end

	always_ff @(posedge Clock) begin
		if (!resetn) begin
			tickCount <= '0;
			frameTick <= 1'b0;
		end else if (tickCount == tickBits'(`FRAME_TICKS - 1)) begin
			tickCount <= '0;
			frameTick <= 1'b1;
		end else begin
			tickCount <= tickCount + 1'b1;
			frameTick <= 1'b0;
		end
	end

	// XNOR feedback taken over bits 2 to 17
	always_ff @(posedge Clock) begin
		if (!resetn) begin
			lfsr <= lfsrSeeds;
		end else begin
			for (int c = 0; c < `NUM_COLUMNS; c++) begin
				lfsr[c] <= {lfsr[c][29:0], ~^lfsr[c][17:2]};
			end
		end
	end

endmodule

`default_nettype wire

//--- laneStore.sv
`timescale 1ns/1ps
`default_nettype none

`include "pianoTiles_defs.svh"

module laneStore (
	input logic Clock,
	input logic resetn,
	input logic step,
	input gamePkg::columnMaskT pressMask,
	input gamePkg::columnMaskT randomBits,
	output gamePkg::columnMaskT hitMask,
	output logic miss,
	renderIf.lanes rd
);

	gamePkg::lanesT lanes;
	gamePkg::lanesT nextLanes;
	logic [4:0] spawnCount;
	gamePkg::columnMaskT pending;
	gamePkg::columnMaskT judged;
	gamePkg::columnMaskT bottomRow;

	// Clears the contiguous tile run ending at the bottom row
	function automatic gamePkg::laneT clearRun(input gamePkg::laneT lane);
		gamePkg::laneT result;
		logic inRun;
		result = lane;
		inRun = 1'b1;
		for (int i = 0; i < `BLOCK_ROWS; i++) begin
			if (inRun && lane[`LANE_ROWS-1-i]) begin
				result[`LANE_ROWS-1-i] = 1'b0;
			end else begin
				inRun = 1'b0;
			end
		end
		return result;
	endfunction

	assign judged = pending | pressMask; // A press in the step cycle counts too
	assign hitMask = judged & bottomRow;
	assign miss = |(judged & ~bottomRow);

	always_comb begin
		for (int c = 0; c < `NUM_COLUMNS; c++) begin
			bottomRow[c] = lanes[c][`LANE_ROWS-1];
		end
	end

	always_comb begin
		for (int c = 0; c < `NUM_COLUMNS; c++) begin
			nextLanes[c] = hitMask[c] ? clearRun(lanes[c]) : lanes[c];
			if (spawnCount == 5'(`BLOCK_ROWS)) begin
				nextLanes[c][`BLOCK_ROWS-1:0] = {`BLOCK_ROWS{randomBits[c]}};
			end else begin
				nextLanes[c] = nextLanes[c] << 1; // Row r moves to row r+1
			end
		end
	end

	always_comb begin
		for (int c = 0; c < `NUM_COLUMNS; c++) begin
			if (rd.rowAddr < 7'(`LANE_ROWS)) begin
				rd.rowBits[c] = lanes[c][rd.rowAddr];
			end else begin
				rd.rowBits[c] = 1'b0;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (!resetn) begin
			lanes <= '0;
			spawnCount <= '0;
			pending <= '0;
		end else if (step) begin
			lanes <= nextLanes;
			pending <= '0;
			if (spawnCount == 5'(`SPAWN_PERIOD - 1)) begin
				spawnCount <= '0;
			end else begin
				spawnCount <= spawnCount + 1'b1;
			end
		end else begin
			pending <= pending | pressMask; // Repeats before a step merge
		end
	end

endmodule

`default_nettype wire

//--- gameController.sv
`timescale 1ns/1ps
`default_nettype none

`include "pianoTiles_defs.svh"

module gameController (
	input logic Clock,
	input logic resetn,
	input logic frameTick,
	input gamePkg::columnMaskT hitMask,
	input logic miss,
	output logic step,
	output gamePkg::scoreT score,
	output logic gameOver,
	renderIf.controller ctl
);

	typedef enum logic [2:0] {
		stIdle,
		stErase,
		stStep,
		stDraw,
		stDead
	} stateT;

	stateT state;
	logic [2:0] hitCount;

	always_comb begin
		hitCount = '0;
		for (int c = 0; c < `NUM_COLUMNS; c++) begin
			hitCount = hitCount + 3'(hitMask[c]);
		end
	end

	assign step = (state == stStep);
	assign gameOver = (state == stDead);

	always_ff @(posedge Clock) begin
		if (!resetn) begin
			state <= stIdle;
			score <= '0;
			ctl.start <= 1'b0;
			ctl.erase <= 1'b0;
		end else begin
			ctl.start <= 1'b0;
			case (state)
				stIdle: if (frameTick) begin // Ticks elsewhere are dropped
					state <= stErase;
					ctl.start <= 1'b1;
					ctl.erase <= 1'b1;
				end
				stErase: if (ctl.done) state <= stStep;
				stStep: if (miss) begin
					state <= stDead; // Score stays frozen
				end else begin
					score <= score + 16'(hitCount);
					state <= stDraw;
					ctl.start <= 1'b1;
					ctl.erase <= 1'b0;
				end
				stDraw: if (ctl.done) state <= stIdle;
				stDead: state <= stDead;
				default: state <= stIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- tileRenderer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pianoTiles_defs.svh"

module tileRenderer (
	input logic Clock,
	input logic resetn,
	output videoPkg::xT x,
	output videoPkg::yT y,
	output videoPkg::colourT colour,
	output logic plot,
	output logic renderBusy,
	renderIf.renderer rd
);

	logic busy;
	gamePkg::columnT column;
	logic [3:0] pixel;
	logic tileSet;
	videoPkg::xT columnBase;

	assign tileSet = rd.rowBits[column];
	assign columnBase = 8'(`COLUMN_X0) + 8'(column) * 8'(`COLUMN_PITCH);

	// Scan order is rows 0 to 119, columns 0 to 3, then tile pixels
	always_ff @(posedge Clock) begin
		if (!resetn) begin
			busy <= 1'b0;
			rd.rowAddr <= '0;
			column <= '0;
			pixel <= '0;
			rd.done <= 1'b0;
			plot <= 1'b0;
			renderBusy <= 1'b0;
		end else begin
			rd.done <= 1'b0;
			plot <= busy && tileSet;
			renderBusy <= busy; // Lines up with the plot stream
			if (rd.start && !busy) begin
				busy <= 1'b1;
				rd.rowAddr <= '0;
				column <= '0;
				pixel <= '0;
			end else if (busy) begin
				if (tileSet && pixel != 4'(`TILE_WIDTH - 1)) begin
					pixel <= pixel + 1'b1;
				end else begin
					pixel <= '0;
					column <= column + 1'b1;
					if (column == 2'(`NUM_COLUMNS - 1)) begin
						if (rd.rowAddr == 7'(`LANE_ROWS - 1)) begin
							busy <= 1'b0;
							rd.done <= 1'b1;
						end else begin
							rd.rowAddr <= rd.rowAddr + 1'b1;
						end
					end
				end
			end
		end
	end

	always_ff @(posedge Clock) begin
		x <= columnBase + 8'(pixel);
		y <= rd.rowAddr;
		colour <= rd.erase ? videoPkg::colourErase : videoPkg::colourDraw;
	end

endmodule

`default_nettype wire

//--- scoreDisplay.sv
`timescale 1ns/1ps
`default_nettype none

module scoreDisplay (
	input gamePkg::scoreT score,
	output videoPkg::digitsT digits
);

	function automatic videoPkg::segmentsT hexSegments(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'b100_0000;
			4'h1: return 7'b111_1001;
			4'h2: return 7'b010_0100;
			4'h3: return 7'b011_0000;
			4'h4: return 7'b001_1001;
			4'h5: return 7'b001_0010;
			4'h6: return 7'b000_0010;
			4'h7: return 7'b111_1000;
			4'h8: return 7'b000_0000;
			4'h9: return 7'b001_1000;
			4'hA: return 7'b000_1000;
			4'hB: return 7'b000_0011;
			4'hC: return 7'b100_0110;
			4'hD: return 7'b010_0001;
			4'hE: return 7'b000_0110;
			default: return 7'b000_1110; // F
		endcase
	endfunction

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			digits[i] = hexSegments(score[4*i +: 4]); // Digit 0 is the low nibble
		end
	end

endmodule

`default_nettype wire

//--- pianoTiles.sv
`timescale 1ns/1ps
`default_nettype none

module pianoTiles (
	input logic Clock,
	input logic resetn,
	input logic [3:0] keysN,
	output videoPkg::xT x,
	output videoPkg::yT y,
	output videoPkg::colourT colour,
	output logic plot,
	output logic renderBusy,
	output logic gameOver,
	output videoPkg::segmentsT hex0,
	output videoPkg::segmentsT hex1,
	output videoPkg::segmentsT hex2,
	output videoPkg::segmentsT hex3
);

	gamePkg::columnMaskT pressMask;
	gamePkg::columnMaskT randomBits;
	gamePkg::columnMaskT hitMask;
	gamePkg::scoreT score;
	videoPkg::digitsT digits;
	logic frameTick;
	logic step;
	logic miss;

	renderIf renderBus ();

	inputSide i_inputSide (
		.Clock(Clock),
		.resetn(resetn),
		.keysN(keysN),
		.pressMask(pressMask),
		.frameTick(frameTick),
		.randomBits(randomBits)
	);

	laneStore i_laneStore (
		.Clock(Clock),
		.resetn(resetn),
		.step(step),
		.pressMask(pressMask),
		.randomBits(randomBits),
		.hitMask(hitMask),
		.miss(miss),
		.rd(renderBus.lanes)
	);

	gameController i_gameController (
		.Clock(Clock),
		.resetn(resetn),
		.frameTick(frameTick),
		.hitMask(hitMask),
		.miss(miss),
		.step(step),
		.score(score),
		.gameOver(gameOver),
		.ctl(renderBus.controller)
	);

	tileRenderer i_tileRenderer (
		.Clock(Clock),
		.resetn(resetn),
		.x(x),
		.y(y),
		.colour(colour),
		.plot(plot),
		.renderBusy(renderBusy),
		.rd(renderBus.renderer)
	);

	scoreDisplay i_scoreDisplay (
		.score(score),
		.digits(digits)
	);

	assign hex0 = digits[0];
	assign hex1 = digits[1];
	assign hex2 = digits[2];
	assign hex3 = digits[3];

endmodule

`default_nettype wire

//--- tbPianoTiles.sv
`timescale 1ns/1ps
`default_nettype none

`include "pianoTiles_defs.svh"

module tbPianoTiles;

	localparam int clockPeriod = 40;
	localparam int resetCycles = 16;
	localparam int retryLimit = 44; // Two spawn periods
	localparam int numEntries = 7;

	// Kind 0 fixed mask, 1 random mask, 2 repeated presses, 3 miss
	localparam int entryFrames [numEntries] = '{122, 1, 2, 1, 1, 1, 1};
	localparam logic [3:0] entryMask [numEntries] = '{4'hF, 4'h0, 4'h5, 4'h0, 4'h0, 4'h0, 4'h0};
	localparam int entryKind [numEntries] = '{0, 1, 0, 2, 1, 1, 3};

	// Active-low segments, bit 6 is g
	localparam logic [6:0] segTable [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02,
		7'h78, 7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

	logic Clock = 1'b0;
	logic resetn;
	logic [3:0] keysN;
	videoPkg::xT x;
	videoPkg::yT y;
	videoPkg::colourT colour;
	logic plot;
	logic renderBusy;
	logic gameOver;
	videoPkg::segmentsT hex0;
	videoPkg::segmentsT hex1;
	videoPkg::segmentsT hex2;
	videoPkg::segmentsT hex3;

	integer seed;
	int stateErrors;
	logic [15:0] shadowScore;
	logic expectGameOver;

	int streamErrors = 0;
	int drawCount = 0;
	int drawPixels = 0;
	int passPixels = 0;
	int runLen = 0;
	int lastX = 0;
	int lastY = 0;
	logic busyLast = 1'b0;
	logic passDraw = 1'b0;
	logic gameOverSeen = 1'b0;
	logic [3:0] bottomNow = 4'h0;
	logic [3:0] shadowBottom = 4'h0; // Bit c set when column c has pixels at y = 119
	logic [3:0] bottomHistory [0:1023];
	bit drawMap [0:119][0:109];

	pianoTiles i_pianoTiles (
		.Clock(Clock),
		.resetn(resetn),
		.keysN(keysN),
		.x(x),
		.y(y),
		.colour(colour),
		.plot(plot),
		.renderBusy(renderBusy),
		.gameOver(gameOver),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3)
	);

	always #(clockPeriod / 2) Clock = ~Clock;

	function automatic bit inSpan(input int px, input int py);
		return py < `LANE_ROWS && px >= `COLUMN_X0
			&& px < `COLUMN_X0 + `NUM_COLUMNS * `COLUMN_PITCH
			&& (px - `COLUMN_X0) % `COLUMN_PITCH < `TILE_WIDTH;
	endfunction

	task automatic checkPixel(input int px, input int py);
		int col;
		if (colour !== (passDraw ? 3'd7 : 3'd0)) begin
			$display("error: colour = %h, expected %h", colour, passDraw ? 3'd7 : 3'd0);
			streamErrors++;
		end
		if (!inSpan(px, py)) begin
			$display("error: x = %h, y = %h lies outside every column span", x, y);
			streamErrors++;
			runLen = 0;
		end else begin
			if (runLen == 0 && (px - `COLUMN_X0) % `COLUMN_PITCH != 0) begin
				$display("error: tile run starts at x = %h", x);
				streamErrors++;
			end else if (runLen != 0 && (px != lastX + 1 || py != lastY)) begin
				$display("error: x = %h, y = %h breaks the run after x = %h, y = %h",
					x, y, lastX, lastY);
				streamErrors++;
			end
			runLen = (runLen == `TILE_WIDTH - 1) ? 0 : runLen + 1;
			lastX = px;
			lastY = py;
			col = (px - `COLUMN_X0) / `COLUMN_PITCH;
			if (passDraw) begin
				drawMap[py][px] = 1'b1;
				if (py == `LANE_ROWS - 1) bottomNow[col] = 1'b1;
			end else if (!drawMap[py][px]) begin
				$display("error: erase of x = %h, y = %h missing from the last draw pass", x, y);
				streamErrors++;
			end
		end
		passPixels++;
	endtask

	// Pixel stream monitor and shadow of the drawn lanes
	always @(negedge Clock) begin
		int px;
		int py;
		px = int'(x);
		py = int'(y);
		if (resetn) begin
			if (gameOver) gameOverSeen = 1'b1;
			if (plot && !renderBusy) begin
				$display("error: plot = %h while renderBusy = %h", plot, renderBusy);
				streamErrors++;
			end
			if (plot && gameOverSeen) begin
				$display("error: plot = %h after gameOver", plot);
				streamErrors++;
			end
			if (renderBusy && !busyLast) begin
				passDraw = (colour == 3'd7);
				passPixels = 0;
				runLen = 0;
				bottomNow = 4'h0;
				if (passDraw) begin
					for (int r = 0; r < `LANE_ROWS; r++) begin
						for (int c = 0; c < 110; c++) drawMap[r][c] = 1'b0;
					end
				end
			end
			if (plot) begin
				checkPixel(px, py);
			end else if (renderBusy && runLen != 0) begin
				$display("Tile run at y = %0d ended after %0d pixels", lastY, runLen);
				streamErrors++;
				runLen = 0;
			end
			if (!renderBusy && busyLast) begin
				if (runLen != 0) begin
					$display("Pass ended inside a tile run");
					streamErrors++;
				end
				if (passDraw) begin
					drawPixels = passPixels;
					shadowBottom = bottomNow;
					drawCount++;
					bottomHistory[drawCount] = bottomNow;
				end else if (passPixels != drawPixels) begin
					$display("error: erase pixel count = %h, expected %h", passPixels, drawPixels);
					streamErrors++;
				end
			end
			busyLast = renderBusy;
		end
	end

	task automatic checkDigit(input string name, input videoPkg::segmentsT shown,
		input logic [3:0] nibble);
		if (shown !== segTable[nibble]) begin
			$display("error: %s = %h, expected %h", name, shown, segTable[nibble]);
			stateErrors++;
		end
	endtask

	task automatic checkDisplay;
		checkDigit("hex0", hex0, shadowScore[3:0]);
		checkDigit("hex1", hex1, shadowScore[7:4]);
		checkDigit("hex2", hex2, shadowScore[11:8]);
		checkDigit("hex3", hex3, shadowScore[15:12]);
	endtask

	task automatic checkIdle;
		if (plot !== 1'b0 || renderBusy !== 1'b0 || gameOver !== 1'b0) begin
			$display("error: plot = %h, renderBusy = %h, gameOver = %h, expected 0",
				plot, renderBusy, gameOver);
			stateErrors++;
		end
		checkDisplay();
	endtask

	task automatic waitDraws(input int frames);
		int target;
		target = drawCount + frames;
		while (drawCount < target) @(negedge Clock);
	endtask

	task automatic pressKeys(input logic [3:0] mask);
		for (int c = 0; c < `NUM_COLUMNS; c++) begin
			keysN[`NUM_COLUMNS-1-c] = ~mask[c]; // keysN[3] is column 0
		end
		repeat (4) @(negedge Clock);
		keysN = 4'hF;
		repeat (4) @(negedge Clock);
	endtask

	task automatic pickColumns(input int kind, input logic [3:0] mask, output logic [3:0] chosen);
		case (kind)
			0: chosen = mask & shadowBottom;
			1: chosen = 4'($random(seed)) & shadowBottom;
			2: chosen = shadowBottom & (~shadowBottom + 4'h1); // Lowest filled column
			default: chosen = ~shadowBottom & (shadowBottom + 4'h1); // Lowest empty column
		endcase
	endtask

	task automatic applyEntry(input int entry, input int kind, input logic [3:0] chosen);
		int pressDraw;
		pressDraw = drawCount;
		if (chosen != 4'h0) begin
			repeat ((kind == 2) ? 3 : 1) pressKeys(chosen);
		end
		if (kind == 3) begin
			if (chosen == 4'h0) begin
				$display("No empty bottom row found for the miss in entry %0d", entry);
				stateErrors++;
			end
			expectGameOver = (chosen != 4'h0);
		end else begin
			shadowScore = shadowScore + 16'($countones(chosen));
		end
		repeat (2 * `FRAME_TICKS) @(negedge Clock);
		if (gameOver !== expectGameOver) begin
			$display("error: gameOver = %h, expected %h", gameOver, expectGameOver);
			stateErrors++;
		end
		checkDisplay();
		if (kind != 3 && chosen != 4'h0) begin
			if (drawCount <= pressDraw) begin
				$display("No draw pass followed the press in entry %0d", entry);
				stateErrors++;
			end else if ((bottomHistory[pressDraw + 1] & chosen) != 4'h0) begin
				$display("error: bottom row = %h after hitting columns %h",
					bottomHistory[pressDraw + 1], chosen);
				stateErrors++;
			end
		end
	endtask

	initial begin
		logic [3:0] chosen;
		int tries;
		resetn = 1'b0;
		keysN = 4'hF; // Keys released
		seed = 32'he900;
		stateErrors = 0;
		shadowScore = 16'h0;
		expectGameOver = 1'b0;
		repeat (resetCycles) begin
			@(negedge Clock);
			checkIdle();
		end
		resetn = 1'b1;
		@(negedge Clock);
		checkIdle();
		for (int e = 0; e < numEntries; e++) begin
			waitDraws(entryFrames[e]);
			pickColumns(entryKind[e], entryMask[e], chosen);
			tries = 0;
			while (chosen == 4'h0 && tries < retryLimit) begin
				waitDraws(1);
				pickColumns(entryKind[e], entryMask[e], chosen);
				tries++;
			end
			if (chosen == 4'h0 && entryKind[e] != 3) begin
				$display("Entry %0d found no filled column and pressed nothing", e);
			end
			applyEntry(e, entryKind[e], chosen);
		end
		repeat (3 * `FRAME_TICKS) @(negedge Clock); // Plot must stay low after the miss
		checkDisplay();
		$display("Errors: %0d in the pixel stream, %0d in score and state",
			streamErrors, stateErrors);
		if (streamErrors + stateErrors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Watchdog sized from the table, with retries and check waits
	initial begin
		longint frames;
		frames = 0;
		for (int e = 0; e < numEntries; e++) begin
			frames += longint'(entryFrames[e] + retryLimit + 2);
		end
		#((frames + 4) * 2 * `FRAME_TICKS * clockPeriod);
		$display("Timeout: the run did not finish in time");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
gamePkg.sv
videoPkg.sv
renderIf.sv
inputSide.sv
laneStore.sv
gameController.sv
tileRenderer.sv
scoreDisplay.sv
pianoTiles.sv
tbPianoTiles.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tbPianoTiles -o simPianoTiles
./obj_dir/simPianoTiles | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
